/* alu_unit.sv */
/* Integer ALU of the execute stage
 * Add, subtract, logic, shifts, set-less-than, LUI and link address
 */
`timescale 1ns/100ps

module alu_unit (
    input  exec_pkg::op_e   operation_i,
    input  exec_pkg::word_t pc_i,
    input  exec_pkg::word_t first_operand_i,
    input  exec_pkg::word_t second_operand_i,
    output exec_pkg::word_t alu_result_o
);
    import exec_pkg::*;

    shamt_t shamt;
    word_t  sum_result;
    word_t  diff_result;
    word_t  link_result;
    word_t  and_result;
    word_t  or_result;
    word_t  xor_result;
    word_t  sll_result;
    word_t  srl_result;
    word_t  sra_result;
    logic   less_than;
    logic   less_than_unsigned;

    // Only the low bits of the second operand count as shift amount
    assign shamt = second_operand_i[SHAMT_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sum_result  = first_operand_i + second_operand_i;
        diff_result = first_operand_i - second_operand_i;
        link_result = pc_i + LINK_OFFSET;

        and_result  = first_operand_i & second_operand_i;
        or_result   = first_operand_i | second_operand_i;
        xor_result  = first_operand_i ^ second_operand_i;

        sll_result  = first_operand_i << shamt;
        srl_result  = first_operand_i >> shamt;
        sra_result  = word_t'($signed(first_operand_i) >>> shamt);

        less_than          = $signed(first_operand_i) < $signed(second_operand_i);
        less_than_unsigned = first_operand_i < second_operand_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (operation_i)
            SUB:        alu_result_o = diff_result;
            AND:        alu_result_o = and_result;
            OR:         alu_result_o = or_result;
            XOR:        alu_result_o = xor_result;
            SLL:        alu_result_o = sll_result;
            SRL:        alu_result_o = srl_result;
            SRA:        alu_result_o = sra_result;
            SLT:        alu_result_o = {{(XLEN-1){1'b0}}, less_than};
            SLTU:       alu_result_o = {{(XLEN-1){1'b0}}, less_than_unsigned};
            // Upper immediate arrives already shifted
            LUI:        alu_result_o = second_operand_i;
            JAL, JALR:  alu_result_o = link_result;
            default:    alu_result_o = sum_result;
        endcase
    end

endmodule

/* branch_unit.sv */
/* Branch unit of the execute stage
 * Compare conditions and jump target
 */
`timescale 1ns/100ps

module branch_unit (
    input  exec_pkg::op_e   operation_i,
    input  exec_pkg::word_t pc_i,
    input  exec_pkg::word_t first_operand_i,
    input  exec_pkg::word_t second_operand_i,
    input  exec_pkg::word_t third_operand_i,
    output logic            branch_taken_o,
    output exec_pkg::word_t jump_target_o
);
    import exec_pkg::*;

    word_t reg_target;
    word_t pc_target;
    logic  equal;
    logic  less_than;
    logic  less_than_unsigned;

    assign equal              = (first_operand_i == second_operand_i);
    assign less_than          = $signed(first_operand_i) < $signed(second_operand_i);
    assign less_than_unsigned = first_operand_i < second_operand_i;

    always_comb begin
        unique case (operation_i)
            BEQ:        branch_taken_o = equal;
            BNE:        branch_taken_o = !equal;
            BLT:        branch_taken_o = less_than;
            BLTU:       branch_taken_o = less_than_unsigned;
            BGE:        branch_taken_o = !less_than;
            BGEU:       branch_taken_o = !less_than_unsigned;
            JAL, JALR:  branch_taken_o = 1'b1;
            default:    branch_taken_o = 1'b0;
        endcase
    end

    // Jumps add the operands, branches offset the pc
    assign reg_target = first_operand_i + second_operand_i;
    assign pc_target  = pc_i + third_operand_i;

    always_comb begin
        unique case (operation_i)
            JAL:        jump_target_o = reg_target;
            JALR:       jump_target_o = {reg_target[XLEN-1:1], 1'b0};
            default:    jump_target_o = pc_target;
        endcase
    end

    // Only branches and jumps are ever taken
    always_comb begin
        assert (branch_taken_o == 1'b0 || operation_i inside
                {BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR})
            else $error("branch_unit: taken on a non-branch operation");
    end

endmodule

/* exec_pkg.sv */
/* Shared definitions for the execute stage
 * Widths, word and tag types, operation and trap-cause encodings
 */
package exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN    = 32;
    localparam int TAG_W   = 3;
    localparam int SHAMT_W = 5;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    // Step from a jump to its return address
    localparam word_t LINK_OFFSET = word_t'(4);

    ////////////////////////////////////////////////////////////////////////////
    // Operations
    ////////////////////////////////////////////////////////////////////////////

    // Decoded operation presented by the decode stage
    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        ECALL,
        EBREAK,
        MRET,
        NOP
    } op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Trap causes
    ////////////////////////////////////////////////////////////////////////////

    // Machine cause values, NE when nothing is raised
    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        ECALL_FROM_MMODE               = 5'd11,
        NE                             = 5'd31
    } exc_code_e;

endpackage

/* execute_stage.sv */
/* Execute stage top level
 * Flow control, ALU, branch unit and result registers
 */
`timescale 1ns/100ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,

    input  exec_pkg::word_t     pc_i,
    input  exec_pkg::word_t     first_operand_i,
    input  exec_pkg::word_t     second_operand_i,
    input  exec_pkg::word_t     third_operand_i,
    input  exec_pkg::op_e       operation_i,
    input  exec_pkg::tag_t      tag_i,

    input  logic                exc_illegal_inst_i,
    input  logic                exc_misaligned_fetch_i,
    input  logic                interrupt_pending_i,

    output logic                killed_o,
    output logic                jump_o,
    output exec_pkg::word_t     jump_target_o,

    output logic                raise_exception_o,
    output exec_pkg::exc_code_e exception_code_o,
    output logic                machine_return_o,
    output logic                interrupt_ack_o,

    output logic                write_enable_o,
    output exec_pkg::op_e       operation_o,
    output exec_pkg::word_t     result_o
);
    import exec_pkg::*;

    logic  branch_taken;
    word_t alu_result;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    flow_control i_flow_control (
        .clk                    (clk),
        .reset                  (reset),
        .operation_i            (operation_i),
        .tag_i                  (tag_i),
        .branch_taken_i         (branch_taken),
        .exc_illegal_inst_i     (exc_illegal_inst_i),
        .exc_misaligned_fetch_i (exc_misaligned_fetch_i),
        .interrupt_pending_i    (interrupt_pending_i),
        .killed_o               (killed_o),
        .jump_o                 (jump_o),
        .raise_exception_o      (raise_exception_o),
        .exception_code_o       (exception_code_o),
        .machine_return_o       (machine_return_o),
        .interrupt_ack_o        (interrupt_ack_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Processing
    ////////////////////////////////////////////////////////////////////////////

    alu_unit i_alu_unit (
        .operation_i      (operation_i),
        .pc_i             (pc_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .alu_result_o     (alu_result)
    );

    branch_unit i_branch_unit (
        .operation_i      (operation_i),
        .pc_i             (pc_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .third_operand_i  (third_operand_i),
        .branch_taken_o   (branch_taken),
        .jump_target_o    (jump_target_o)
    );

    // Output side
    result_stage i_result_stage (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .killed_i       (killed_o),
        .operation_i    (operation_i),
        .alu_result_i   (alu_result),
        .write_enable_o (write_enable_o),
        .operation_o    (operation_o),
        .result_o       (result_o)
    );

endmodule

/* flow_control.sv */
/* Flow control of the execute stage
 * Tag register, wrong-path kill, branch qualification and trap priority
 */
`timescale 1ns/100ps

module flow_control (
    input  logic                clk,
    input  logic                reset,
    input  exec_pkg::op_e       operation_i,
    input  exec_pkg::tag_t      tag_i,
    input  logic                branch_taken_i,
    input  logic                exc_illegal_inst_i,
    input  logic                exc_misaligned_fetch_i,
    input  logic                interrupt_pending_i,
    output logic                killed_o,
    output logic                jump_o,
    output logic                raise_exception_o,
    output exec_pkg::exc_code_e exception_code_o,
    output logic                machine_return_o,
    output logic                interrupt_ack_o
);
    import exec_pkg::*;

    tag_t curr_tag;
    logic live;
    logic redirect;

    // Instructions fetched before the last redirect carry a stale tag
    assign killed_o = (curr_tag != tag_i);
    assign live     = !killed_o && !reset;

    assign jump_o   = branch_taken_i && live;

    ////////////////////////////////////////////////////////////////////////////
    // Trap priority
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        raise_exception_o = 1'b0;
        exception_code_o  = NE;
        machine_return_o  = 1'b0;
        interrupt_ack_o   = 1'b0;
        if (live) begin
            if (exc_illegal_inst_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = ILLEGAL_INSTRUCTION;
            end else if (exc_misaligned_fetch_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (operation_i == ECALL) begin
                raise_exception_o = 1'b1;
                exception_code_o  = ECALL_FROM_MMODE;
            end else if (operation_i == EBREAK) begin
                raise_exception_o = 1'b1;
                exception_code_o  = BREAKPOINT;
            end else if (operation_i == MRET) begin
                machine_return_o  = 1'b1;
            end else if (interrupt_pending_i) begin
                // Interrupts are taken only between other actions
                interrupt_ack_o   = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag register
    ////////////////////////////////////////////////////////////////////////////

    assign redirect = jump_o || raise_exception_o || machine_return_o || interrupt_ack_o;

    // Advances regardless of stall, wraps modulo 8
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (redirect) begin
            curr_tag <= curr_tag + tag_t'(1);
        end
    end

    // Trap actions never overlap, and a cause only comes with a raised exception
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({raise_exception_o, machine_return_o, interrupt_ack_o})
        && (raise_exception_o || exception_code_o == NE))
        else $error("flow_control: overlapping trap actions");

endmodule

/* list.f */
exec_pkg.sv
flow_control.sv
alu_unit.sv
branch_unit.sv
result_stage.sv
execute_stage.sv
tb_execute_stage.sv

/* result_stage.sv */
/* Output side of the execute stage
 * Write-enable decision and the stall-held result registers
 */
`timescale 1ns/100ps

module result_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_i,
    input  logic            killed_i,
    input  exec_pkg::op_e   operation_i,
    input  exec_pkg::word_t alu_result_i,
    output logic            write_enable_o,
    output exec_pkg::op_e   operation_o,
    output exec_pkg::word_t result_o
);
    import exec_pkg::*;

    logic write_enable;

    // No register write for branches, system ops or killed instructions
    always_comb begin
        unique case (operation_i)
            BEQ, BNE,
            BLT, BLTU,
            BGE, BGEU,
            ECALL, EBREAK,
            MRET, NOP:  write_enable = 1'b0;
            default:    write_enable = !killed_i;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            operation_o <= operation_i;
            result_o    <= alu_result_i;
        end
    end

    // A stalled edge leaves all outputs as they were
    assert property (@(posedge clk) disable iff (reset)
        stall_i |=> $stable(write_enable_o) && $stable(operation_o) && $stable(result_o))
        else $error("result_stage: output changed across a stall");

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_execute_stage \
    -f list.f -o sim_execute_stage &&
./obj_dir/sim_execute_stage | tee /dev/stderr | grep -qF "TEST RESULT: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* tb_execute_stage.sv */
/* Testbench for the execute stage
 * Random stimulus with a model tag, reference model and checking assertions
 */
`timescale 1ns/100ps

module tb_execute_stage;
    import exec_pkg::*;

    localparam int MIN_CYCLES = 2000;
    localparam int MAX_CYCLES = 20000;

    logic      clk = 1'b0;
    logic      reset;
    logic      stall_i;
    word_t     pc_i;
    word_t     first_operand_i;
    word_t     second_operand_i;
    word_t     third_operand_i;
    op_e       operation_i;
    tag_t      tag_i;
    logic      exc_illegal_inst_i;
    logic      exc_misaligned_fetch_i;
    logic      interrupt_pending_i;

    logic      killed_o;
    logic      jump_o;
    word_t     jump_target_o;
    logic      raise_exception_o;
    exc_code_e exception_code_o;
    logic      machine_return_o;
    logic      interrupt_ack_o;
    logic      write_enable_o;
    op_e       operation_o;
    word_t     result_o;

    integer    seed;
    int        cycles;
    int        n_jump = 0;
    int        n_killed = 0;
    int        n_stall = 0;
    int        n_write = 0;
    int        n_mret = 0;
    int        n_iack = 0;
    int        n_cause [32] = '{default: 0};

    // Reference model state
    tag_t      model_tag = '0;
    logic      reset_seen = 1'b0;
    logic      have_result = 1'b0;
    logic      exp_we = 1'b0;
    op_e       exp_op;
    word_t     exp_result;
    logic      exp_killed;
    logic      exp_jump;
    word_t     exp_target;
    logic      exp_raise;
    exc_code_e exp_code;
    logic      exp_mret;
    logic      exp_iack;
    logic      exp_redirect;

    execute_stage i_execute_stage (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t alu_expect(op_e op, word_t pc, word_t a, word_t b);
        shamt_t sh;
        sh = b[SHAMT_W-1:0];
        case (op)
            SUB:       return a - b;
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            SLL:       return a << sh;
            SRL:       return a >> sh;
            SRA:       return (a >> sh) | (a[XLEN-1] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            // Signed compare by flipping the sign bits
            SLT:       return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            SLTU:      return (a < b) ? 32'd1 : 32'd0;
            LUI:       return b;
            JAL, JALR: return pc + 32'd4;
            default:   return a + b;
        endcase
    endfunction

    function automatic logic taken_expect(op_e op, word_t a, word_t b);
        logic lt_s;
        logic lt_u;
        lt_u = a < b;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op)
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return lt_s;
            BLTU:      return lt_u;
            BGE:       return !lt_s;
            BGEU:      return !lt_u;
            JAL, JALR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    // ADD up to JALR are the register-writing operations
    function automatic logic writes_register(op_e op);
        return op <= JALR;
    endfunction

    always_comb begin
        exp_killed = (tag_i != model_tag);
        exp_jump   = !exp_killed && taken_expect(operation_i, first_operand_i, second_operand_i);
        if (operation_i == JAL)
            exp_target = first_operand_i + second_operand_i;
        else if (operation_i == JALR)
            exp_target = (first_operand_i + second_operand_i) & 32'hFFFF_FFFE;
        else
            exp_target = pc_i + third_operand_i;
        exp_raise = 1'b0;
        exp_code  = NE;
        exp_mret  = 1'b0;
        exp_iack  = 1'b0;
        if (!exp_killed) begin
            if (exc_illegal_inst_i) begin
                exp_raise = 1'b1;
                exp_code  = ILLEGAL_INSTRUCTION;
            end else if (exc_misaligned_fetch_i) begin
                exp_raise = 1'b1;
                exp_code  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (operation_i == ECALL) begin
                exp_raise = 1'b1;
                exp_code  = ECALL_FROM_MMODE;
            end else if (operation_i == EBREAK) begin
                exp_raise = 1'b1;
                exp_code  = BREAKPOINT;
            end else if (operation_i == MRET) begin
                exp_mret  = 1'b1;
            end else if (interrupt_pending_i) begin
                exp_iack  = 1'b1;
            end
        end
        exp_redirect = exp_jump || exp_raise || exp_mret || exp_iack;
    end

    // Model registers and coverage counters
    always @(posedge clk) begin
        if (reset) begin
            model_tag   <= '0;
            exp_we      <= 1'b0;
            have_result <= 1'b0;
            reset_seen  <= 1'b1;
        end else begin
            if (exp_redirect)
                model_tag <= model_tag + 3'd1;
            if (!stall_i) begin
                exp_we      <= writes_register(operation_i) && !exp_killed;
                exp_op      <= operation_i;
                exp_result  <= alu_expect(operation_i, pc_i, first_operand_i,
                                          second_operand_i);
                have_result <= 1'b1;
                n_write     <= n_write + int'(writes_register(operation_i) && !exp_killed);
            end
            n_jump   <= n_jump + int'(exp_jump);
            n_killed <= n_killed + int'(exp_killed);
            n_stall  <= n_stall + int'(stall_i);
            n_mret   <= n_mret + int'(exp_mret);
            n_iack   <= n_iack + int'(exp_iack);
            if (exp_raise)
                n_cause[exp_code] <= n_cause[exp_code] + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "execute stage testbench stopped");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
        stop_with_failure();
    endtask

    assert property (@(posedge clk) reset |-> !jump_o && !raise_exception_o
                     && !machine_return_o && !interrupt_ack_o)
        else report_mismatch("trap and jump outputs in reset", 32'(
            {$sampled(jump_o), $sampled(raise_exception_o),
             $sampled(machine_return_o), $sampled(interrupt_ack_o)}), 32'd0);
    assert property (@(posedge clk) reset_seen |-> write_enable_o == exp_we)
        else report_mismatch("write_enable_o", 32'($sampled(write_enable_o)),
                             32'($sampled(exp_we)));
    assert property (@(posedge clk) disable iff (reset) have_result |-> result_o == exp_result)
        else report_mismatch("result_o", $sampled(result_o), $sampled(exp_result));
    assert property (@(posedge clk) disable iff (reset) have_result |-> operation_o == exp_op)
        else report_mismatch("operation_o", 32'($sampled(operation_o)), 32'($sampled(exp_op)));
    assert property (@(posedge clk) disable iff (reset) killed_o == exp_killed)
        else report_mismatch("killed_o", 32'($sampled(killed_o)), 32'($sampled(exp_killed)));
    assert property (@(posedge clk) disable iff (reset) jump_o == exp_jump)
        else report_mismatch("jump_o", 32'($sampled(jump_o)), 32'($sampled(exp_jump)));
    assert property (@(posedge clk) disable iff (reset) jump_target_o == exp_target)
        else report_mismatch("jump_target_o", $sampled(jump_target_o), $sampled(exp_target));
    assert property (@(posedge clk) disable iff (reset) raise_exception_o == exp_raise)
        else report_mismatch("raise_exception_o", 32'($sampled(raise_exception_o)),
                             32'($sampled(exp_raise)));
    assert property (@(posedge clk) disable iff (reset) exception_code_o == exp_code)
        else report_mismatch("exception_code_o", 32'($sampled(exception_code_o)),
                             32'($sampled(exp_code)));
    assert property (@(posedge clk) disable iff (reset) machine_return_o == exp_mret)
        else report_mismatch("machine_return_o", 32'($sampled(machine_return_o)),
                             32'($sampled(exp_mret)));
    assert property (@(posedge clk) disable iff (reset) interrupt_ack_o == exp_iack)
        else report_mismatch("interrupt_ack_o", 32'($sampled(interrupt_ack_o)),
                             32'($sampled(exp_iack)));

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_random();
        int unsigned r;
        int unsigned sel;
        r   = $random(seed);
        sel = $random(seed);
        stall_i                = (r[1:0] == 2'd0);
        exc_illegal_inst_i     = (r[11:8] == 4'd0);
        exc_misaligned_fetch_i = (r[15:12] == 4'd0);
        interrupt_pending_i    = (r[18:16] == 3'd0);
        // Mostly ALU and branch work, system operations now and then
        if (sel[3:0] == 4'd0)
            operation_i = op_e'(5'(19 + sel[9:8]));
        else
            operation_i = op_e'(5'(sel[31:16] % 19));
        pc_i             = $random(seed) & 32'hFFFF_FFFC;
        first_operand_i  = $random(seed);
        second_operand_i = (r[4:2] == 3'd0) ? first_operand_i : word_t'($random(seed));
        third_operand_i  = $random(seed);
        // About one in eight carries a stale tag
        if (r[7:5] == 3'd0)
            tag_i = model_tag + 3'(1 + r[31:24] % 7);
        else
            tag_i = model_tag;
    endtask

    function automatic logic coverage_reached();
        return n_jump >= 20 && n_killed >= 20 && n_stall >= 20 && n_write >= 20
            && n_mret >= 5 && n_iack >= 5
            && n_cause[ILLEGAL_INSTRUCTION] >= 5 && n_cause[INSTRUCTION_ADDRESS_MISALIGNED] >= 5
            && n_cause[ECALL_FROM_MMODE] >= 5 && n_cause[BREAKPOINT] >= 5;
    endfunction

    initial begin
        seed                   = 32'h0200_4e80;
        reset                  = 1'b1;
        stall_i                = 1'b0;
        pc_i                   = '0;
        first_operand_i        = '0;
        second_operand_i       = '0;
        third_operand_i        = '0;
        // A live jump with trap requests, all held back by reset
        operation_i            = JAL;
        tag_i                  = '0;
        exc_illegal_inst_i     = 1'b1;
        exc_misaligned_fetch_i = 1'b0;
        interrupt_pending_i    = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        while ((!coverage_reached() || cycles < MIN_CYCLES) && cycles < MAX_CYCLES) begin
            @(posedge clk);
            #1 drive_random();
            cycles++;
        end
        // Let the last inputs reach the registered outputs
        @(posedge clk);
        #1 stall_i = 1'b0;
        @(posedge clk);
        @(posedge clk);
        if (coverage_reached()) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Coverage goals not reached within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

endmodule
